/* hw/rp_defines.svh */
// Red Pitaya I/O datapath widths and counts
// shared by the package and every block that sizes a port

`ifndef RP_DEFINES_SVH
`define RP_DEFINES_SVH

// ADC sample width, raw pins and converted value
`define RP_ADC_DW 16

// DAC sample and pin code width
`define RP_DAC_DW 14

// expansion connector, p and n rows together
`define RP_GPIO_DW 16

// PDM level width, channel count and register address width
`define RP_PDM_DW 8
`define RP_PDM_CHN 4
`define RP_PDM_AW 2

`endif

/* hw/rp_pkg.sv */
// Red Pitaya I/O datapath types
// sample, GPIO and PDM words plus the paired channel structs

`include "rp_defines.svh"

package rp_pkg;

  // single samples
  typedef logic signed [`RP_ADC_DW-1:0] adc_smp_t;
  typedef logic signed [`RP_DAC_DW-1:0] dac_smp_t;
  // offset binary code as it goes to the DAC pins
  typedef logic [`RP_DAC_DW-1:0] dac_code_t;

  // one bit per expansion pin
  typedef logic [`RP_GPIO_DW-1:0] gpio_t;

  // PDM level, 0 to full scale minus one
  typedef logic [`RP_PDM_DW-1:0] pdm_lvl_t;

  // channel pairs, ch0 sits in the low half
  typedef struct packed {
    adc_smp_t ch1;
    adc_smp_t ch0;
  } adc_pair_t;

  typedef struct packed {
    dac_smp_t ch1;
    dac_smp_t ch0;
  } dac_pair_t;

  typedef struct packed {
    dac_code_t ch1;
    dac_code_t ch0;
  } dac_code_pair_t;

  // logic generator drive, enable and value per pin
  typedef struct packed {
    gpio_t e;
    gpio_t o;
  } lg_drive_t;

endpackage

/* hw/adc_frontend.sv */
// ADC front end for both channels
// registers the raw pins and turns the negative slope
// offset binary code into two's complement

`timescale 1ns/10ps
`include "rp_defines.svh"

module adc_frontend (
  input  logic               adc_clk,
  input  logic               adc_rst_i,
  // raw ADC pins
  input  rp_pkg::adc_pair_t  adc_raw_i,
  // converted samples, always valid
  output rp_pkg::adc_pair_t  adc_smp_o
);

  // keep the sign, flip the magnitude bits
  function automatic rp_pkg::adc_smp_t adc_conv(input rp_pkg::adc_smp_t raw);
    adc_conv = {raw[`RP_ADC_DW-1], ~raw[`RP_ADC_DW-2:0]};
  endfunction

  ////////////////////////////////////////
  // input register
  ////////////////////////////////////////

  rp_pkg::adc_pair_t adc_raw;

  // sits in the IO block, plain data capture
  always_ff @(posedge adc_clk) begin
    adc_raw <= adc_raw_i;
  end

  ////////////////////////////////////////
  // conversion
  ////////////////////////////////////////

  assign adc_smp_o.ch0 = adc_conv(adc_raw.ch0);
  assign adc_smp_o.ch1 = adc_conv(adc_raw.ch1);

  // samples known once reset is over
  a_adc_known: assert property (
    @(posedge adc_clk) disable iff (adc_rst_i)
    !$isunknown(adc_smp_o)
  ) else $error("adc_frontend: unknown value on adc_smp_o");

endmodule

/* hw/dac_backend.sv */
// DAC back end for both channels
// takes a sample on its strobe, converts it to negative slope
// offset binary and drives the pins from an output register

`timescale 1ns/10ps
`include "rp_defines.svh"

module dac_backend (
  input  logic                   adc_clk,
  input  logic                   adc_rst_i,
  // samples and per channel strobes, bit 0 is ch0
  input  rp_pkg::dac_pair_t      dac_smp_i,
  input  logic [1:0]             dac_vld_i,
  // pin codes and DAC reset pin
  output rp_pkg::dac_code_pair_t dac_code_o,
  output logic                   dac_rst_o
);

  // sign kept, rest inverted
  function automatic rp_pkg::dac_code_t dac_conv(input rp_pkg::dac_smp_t smp);
    dac_conv = {smp[`RP_DAC_DW-1], ~smp[`RP_DAC_DW-2:0]};
  endfunction

  // code of a zero sample
  localparam rp_pkg::dac_code_t DAC_MID = {1'b0, {(`RP_DAC_DW-1){1'b1}}};

  ////////////////////////////////////////
  // capture on strobe
  ////////////////////////////////////////

  rp_pkg::dac_code_pair_t dac_code;

  always_ff @(posedge adc_clk, posedge adc_rst_i) begin
    if (adc_rst_i) begin
      dac_code.ch0 <= DAC_MID;
      dac_code.ch1 <= DAC_MID;
    end else begin
      // a channel without strobe holds its code
      if (dac_vld_i[0]) dac_code.ch0 <= dac_conv(dac_smp_i.ch0);
      if (dac_vld_i[1]) dac_code.ch1 <= dac_conv(dac_smp_i.ch1);
    end
  end

  ////////////////////////////////////////
  // output register and DAC reset
  ////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge adc_rst_i) begin
    if (adc_rst_i) begin
      dac_code_o <= '0;
      dac_rst_o  <= 1'b1;
    end else begin
      dac_code_o <= dac_code;
      dac_rst_o  <= 1'b0;
    end
  end

  // pins stay quiet while the DAC is held in reset
  a_dac_rst_quiet: assert property (
    @(posedge adc_clk) dac_rst_o |-> (dac_code_o == '0)
  ) else $error("dac_backend: dac_code_o not zero during DAC reset");

endmodule

/* hw/exp_gpio_mux.sv */
// expansion connector GPIO multiplexer
// each pin is driven either by the processor GPIO or by the
// logic generator, pad drive registered, pad input double registered

`timescale 1ns/10ps

module exp_gpio_mux (
  input  logic              adc_clk,
  input  logic              adc_rst_i,
  // pin mode, 1 hands the pin to the logic generator
  input  rp_pkg::gpio_t     exp_mode_i,
  // processor GPIO value and tristate
  input  rp_pkg::gpio_t     gpio_o_i,
  input  rp_pkg::gpio_t     gpio_t_i,
  // logic generator drive
  input  rp_pkg::lg_drive_t lg_i,
  // pads
  input  rp_pkg::gpio_t     exp_pad_i,
  output rp_pkg::gpio_t     exp_pad_o,
  output rp_pkg::gpio_t     exp_pad_t_o,
  // pad state back to the processor
  output rp_pkg::gpio_t     gpio_i_o
);

  ////////////////////////////////////////
  // per pin selection
  ////////////////////////////////////////

  rp_pkg::gpio_t exp_o;
  rp_pkg::gpio_t exp_t;

  // value from the selected source
  assign exp_o = (~exp_mode_i & gpio_o_i) | (exp_mode_i & lg_i.o);
  // high impedance unless the selected source drives the pin
  assign exp_t = ~((~exp_mode_i & ~gpio_t_i) | (exp_mode_i & lg_i.e));

  ////////////////////////////////////////
  // pad registers
  ////////////////////////////////////////

  rp_pkg::gpio_t exp_pad_meta;

  always_ff @(posedge adc_clk, posedge adc_rst_i) begin
    if (adc_rst_i) begin
      exp_pad_o    <= '0;
      exp_pad_t_o  <= '0;
      exp_pad_meta <= '0;
      gpio_i_o     <= '0;
    end else begin
      // output side, one stage
      exp_pad_o    <= exp_o;
      exp_pad_t_o  <= exp_t;
      // input side, two stages
      exp_pad_meta <= exp_pad_i;
      gpio_i_o     <= exp_pad_meta;
    end
  end

  // tristate control always resolved after reset
  a_pad_t_known: assert property (
    @(posedge adc_clk) disable iff (adc_rst_i)
    !$isunknown(exp_pad_t_o)
  ) else $error("exp_gpio_mux: unknown value on exp_pad_t_o");

endmodule

/* hw/pdm_bank.sv */
// PDM analog outputs, four channels
// level register file written by a plain strobe, and one first
// order accumulator per channel whose carry is the output bit

`timescale 1ns/10ps
`include "rp_defines.svh"

module pdm_bank (
  input  logic                   adc_clk,
  input  logic                   adc_rst_i,
  // level write port
  input  logic                   pdm_we_i,
  input  logic [`RP_PDM_AW-1:0]  pdm_addr_i,
  input  rp_pkg::pdm_lvl_t       pdm_wdata_i,
  // pulse density outputs
  output logic [`RP_PDM_CHN-1:0] pdm_o
);

  ////////////////////////////////////////
  // write port register
  ////////////////////////////////////////

  logic                  wr_en;
  logic [`RP_PDM_AW-1:0] wr_addr;
  rp_pkg::pdm_lvl_t      wr_data;

  // strobe has a reset, address and data are payload
  always_ff @(posedge adc_clk, posedge adc_rst_i) begin
    if (adc_rst_i) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= pdm_we_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    wr_addr <= pdm_addr_i;
    wr_data <= pdm_wdata_i;
  end

  ////////////////////////////////////////
  // level registers
  ////////////////////////////////////////

  rp_pkg::pdm_lvl_t [`RP_PDM_CHN-1:0] pdm_lvl;

  // level lands one edge after the write port register
  always_ff @(posedge adc_clk, posedge adc_rst_i) begin
    if (adc_rst_i) begin
      pdm_lvl <= '0;
    end else if (wr_en) begin
      pdm_lvl[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////
  // modulators
  ////////////////////////////////////////

  for (genvar i = 0; i < `RP_PDM_CHN; i++) begin : g_pdm
    rp_pkg::pdm_lvl_t     acc;
    logic [`RP_PDM_DW:0]  sum;

    // carry out is the pulse, low bits wrap around
    assign sum = {1'b0, acc} + {1'b0, pdm_lvl[i]};

    always_ff @(posedge adc_clk, posedge adc_rst_i) begin
      if (adc_rst_i) begin
        acc      <= '0;
        pdm_o[i] <= 1'b0;
      end else begin
        acc      <= sum[`RP_PDM_DW-1:0];
        pdm_o[i] <= sum[`RP_PDM_DW];
      end
    end
  end

  // a write never targets an unknown register
  a_pdm_addr_known: assert property (
    @(posedge adc_clk) disable iff (adc_rst_i)
    pdm_we_i |-> !$isunknown(pdm_addr_i)
  ) else $error("pdm_bank: write with unknown address");

endmodule

/* hw/rp_io_top.sv */
// Red Pitaya I/O datapath top level
// stages the reset and ties the ADC, DAC, expansion GPIO and
// PDM blocks to the pins, all on adc_clk

`timescale 1ns/10ps
`include "rp_defines.svh"

module rp_io_top (
  input  logic                   adc_clk,
  input  logic                   top_rst,
  // ADC
  input  rp_pkg::adc_pair_t      adc_raw_i,
  output rp_pkg::adc_pair_t      adc_smp_o,
  // DAC
  input  rp_pkg::dac_pair_t      dac_smp_i,
  input  logic [1:0]             dac_vld_i,
  output rp_pkg::dac_code_pair_t dac_code_o,
  output logic                   dac_rst_o,
  // expansion GPIO
  input  rp_pkg::gpio_t          exp_mode_i,
  input  rp_pkg::gpio_t          gpio_o_i,
  input  rp_pkg::gpio_t          gpio_t_i,
  input  rp_pkg::lg_drive_t      lg_i,
  input  rp_pkg::gpio_t          exp_pad_i,
  output rp_pkg::gpio_t          exp_pad_o,
  output rp_pkg::gpio_t          exp_pad_t_o,
  output rp_pkg::gpio_t          gpio_i_o,
  // PDM outputs
  input  logic                   pdm_we_i,
  input  logic [`RP_PDM_AW-1:0]  pdm_addr_i,
  input  rp_pkg::pdm_lvl_t       pdm_wdata_i,
  output logic [`RP_PDM_CHN-1:0] pdm_o
);

  ////////////////////////////////////////
  // reset staging
  ////////////////////////////////////////

  logic adc_rst;

  // asserts at once, releases on the next clock edge
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      adc_rst <= 1'b1;
    end else begin
      adc_rst <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // ADC and DAC
  ////////////////////////////////////////

  adc_frontend adc_frontend (
    .adc_clk    (adc_clk),
    .adc_rst_i  (adc_rst),
    .adc_raw_i  (adc_raw_i),
    .adc_smp_o  (adc_smp_o)
  );

  dac_backend dac_backend (
    .adc_clk    (adc_clk),
    .adc_rst_i  (adc_rst),
    .dac_smp_i  (dac_smp_i),
    .dac_vld_i  (dac_vld_i),
    .dac_code_o (dac_code_o),
    .dac_rst_o  (dac_rst_o)
  );

  ////////////////////////////////////////
  // expansion GPIO and PDM
  ////////////////////////////////////////

  exp_gpio_mux exp_gpio_mux (
    .adc_clk     (adc_clk),
    .adc_rst_i   (adc_rst),
    .exp_mode_i  (exp_mode_i),
    .gpio_o_i    (gpio_o_i),
    .gpio_t_i    (gpio_t_i),
    .lg_i        (lg_i),
    .exp_pad_i   (exp_pad_i),
    .exp_pad_o   (exp_pad_o),
    .exp_pad_t_o (exp_pad_t_o),
    .gpio_i_o    (gpio_i_o)
  );

  pdm_bank pdm_bank (
    .adc_clk     (adc_clk),
    .adc_rst_i   (adc_rst),
    .pdm_we_i    (pdm_we_i),
    .pdm_addr_i  (pdm_addr_i),
    .pdm_wdata_i (pdm_wdata_i),
    .pdm_o       (pdm_o)
  );

endmodule

/* tb/tb_rp_io_top.sv */
// testbench for the Red Pitaya I/O datapath top level
// random stimulus against a cycle model of the ADC, DAC, GPIO and PDM paths

`timescale 1ns/10ps
`include "rp_defines.svh"

module tb_rp_io_top;

  localparam int SEED       = 18509;
  localparam int HALF_PER   = 50;
  localparam int DRV_DLY    = 10;
  localparam int RST_CYCLES = 8;
  localparam int N_RAND     = 300;
  localparam int PDM_ROUNDS = 5;
  localparam int PDM_WIN    = 256;
  // four writes, three edges to the first new bit, then the window
  localparam int PDM_LEN    = PDM_WIN + `RP_PDM_CHN + 2;
  localparam int TEST_CYCLES = RST_CYCLES + 2 + 3 * N_RAND + PDM_ROUNDS * PDM_LEN;
  localparam int MAX_CYCLES = 2 * TEST_CYCLES + 500;
  localparam logic [`RP_ADC_DW-1:0] ADC_MAG = {1'b0, {(`RP_ADC_DW-1){1'b1}}};
  localparam logic [`RP_DAC_DW-1:0] DAC_MAG = {1'b0, {(`RP_DAC_DW-1){1'b1}}};

  logic adc_clk = 1'b0;
  logic top_rst;
  rp_pkg::adc_pair_t      adc_raw_i;
  rp_pkg::adc_pair_t      adc_smp_o;
  rp_pkg::dac_pair_t      dac_smp_i;
  logic [1:0]             dac_vld_i;
  rp_pkg::dac_code_pair_t dac_code_o;
  logic                   dac_rst_o;
  rp_pkg::gpio_t          exp_mode_i;
  rp_pkg::gpio_t          gpio_o_i;
  rp_pkg::gpio_t          gpio_t_i;
  rp_pkg::lg_drive_t      lg_i;
  rp_pkg::gpio_t          exp_pad_i;
  rp_pkg::gpio_t          exp_pad_o;
  rp_pkg::gpio_t          exp_pad_t_o;
  rp_pkg::gpio_t          gpio_i_o;
  logic                   pdm_we_i;
  logic [`RP_PDM_AW-1:0]  pdm_addr_i;
  rp_pkg::pdm_lvl_t       pdm_wdata_i;
  logic [`RP_PDM_CHN-1:0] pdm_o;

  int cycle_cnt = 0;
  int n_checks  = 0;
  int n_errors  = 0;
  int n_tests   = 0;
  int n_failed  = 0;
  int err_base  = 0;

  // PDM model state, write port register, levels, accumulators
  logic                   m_we;
  logic [`RP_PDM_AW-1:0]  m_addr;
  rp_pkg::pdm_lvl_t       m_data;
  rp_pkg::pdm_lvl_t       m_lvl [`RP_PDM_CHN];
  rp_pkg::pdm_lvl_t       m_acc [`RP_PDM_CHN];
  logic [`RP_PDM_CHN-1:0] m_pdm;

  rp_io_top dut0 (.*);

  always #HALF_PER adc_clk = ~adc_clk;

  // run limit
  always @(posedge adc_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout after %0d cycles, tests did not finish", cycle_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // outputs sampled and inputs driven just after the edge
  task automatic tick();
    @(posedge adc_clk);
    #DRV_DLY;
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = n_errors - err_base;
    n_tests++;
    if (errs != 0) begin
      n_failed++;
    end
    $display("test %s done, %0d errors", name, errs);
    err_base = n_errors;
  endtask

  task automatic check_idle_pads();
    check("exp_pad_o", 32'(exp_pad_o), 32'd0);
    check("exp_pad_t_o", 32'(exp_pad_t_o), 32'd0);
    check("gpio_i_o", 32'(gpio_i_o), 32'd0);
    check("pdm_o", 32'(pdm_o), 32'd0);
  endtask

  // one edge of the PDM model, old levels feed the accumulators
  task automatic pdm_model_step();
    logic [`RP_PDM_DW:0] s;
    for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
      s = {1'b0, m_acc[ch]} + {1'b0, m_lvl[ch]};
      m_acc[ch] = s[`RP_PDM_DW-1:0];
      m_pdm[ch] = s[`RP_PDM_DW];
    end
    if (m_we) begin
      m_lvl[m_addr] = m_data;
    end
    m_we   = pdm_we_i;
    m_addr = pdm_addr_i;
    m_data = pdm_wdata_i;
  endtask

  task automatic pdm_step_check();
    tick();
    pdm_model_step();
    check("pdm_o", 32'(pdm_o), 32'(m_pdm));
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic run_adc();
    rp_pkg::adc_pair_t exp_smp;
    for (int i = 0; i <= N_RAND; i++) begin
      tick();
      if (i > 0) begin
        check("adc_smp_o", 32'(adc_smp_o), 32'(exp_smp));
      end
      if (i < N_RAND) begin
        adc_raw_i = $urandom;
        exp_smp.ch0 = adc_raw_i.ch0 ^ ADC_MAG;
        exp_smp.ch1 = adc_raw_i.ch1 ^ ADC_MAG;
      end
    end
  endtask

  task automatic run_dac();
    rp_pkg::dac_code_pair_t q[$];
    rp_pkg::dac_code_pair_t cap;
    rp_pkg::dac_code_pair_t exp_code;
    logic [31:0] r;
    // mid-scale from reset, nothing strobed yet
    cap.ch0 = DAC_MAG;
    cap.ch1 = DAC_MAG;
    q.push_back(cap);
    q.push_back(cap);
    for (int i = 0; i < N_RAND + 2; i++) begin
      tick();
      exp_code = q.pop_front();
      check("dac_code_o", 32'(dac_code_o), 32'(exp_code));
      check("dac_rst_o", 32'(dac_rst_o), 32'd0);
      if (i < N_RAND) begin
        r = $urandom;
        dac_smp_i = r[27:0];
        r = $urandom;
        dac_vld_i = r[1:0];
      end else begin
        dac_vld_i = 2'b00;
      end
      if (dac_vld_i[0]) cap.ch0 = dac_smp_i.ch0 ^ DAC_MAG;
      if (dac_vld_i[1]) cap.ch1 = dac_smp_i.ch1 ^ DAC_MAG;
      q.push_back(cap);
    end
  endtask

  task automatic run_gpio();
    rp_pkg::gpio_t po_q[$];
    rp_pkg::gpio_t pt_q[$];
    rp_pkg::gpio_t pi_q[$];
    rp_pkg::gpio_t e_o;
    rp_pkg::gpio_t e_t;
    logic [31:0] r;
    // idle inputs, processor drives zero on every pin
    po_q.push_back('0);
    pt_q.push_back('0);
    pi_q.push_back('0);
    pi_q.push_back('0);
    for (int i = 0; i < N_RAND + 2; i++) begin
      tick();
      check("exp_pad_o", 32'(exp_pad_o), 32'(po_q.pop_front()));
      check("exp_pad_t_o", 32'(exp_pad_t_o), 32'(pt_q.pop_front()));
      check("gpio_i_o", 32'(gpio_i_o), 32'(pi_q.pop_front()));
      if (i < N_RAND) begin
        r = $urandom;
        exp_mode_i = r[15:0];
        gpio_o_i   = r[31:16];
        r = $urandom;
        gpio_t_i   = r[15:0];
        exp_pad_i  = r[31:16];
        lg_i       = $urandom;
      end
      for (int b = 0; b < `RP_GPIO_DW; b++) begin
        if (exp_mode_i[b]) begin
          e_o[b] = lg_i.o[b];
          e_t[b] = !lg_i.e[b];
        end else begin
          e_o[b] = gpio_o_i[b];
          e_t[b] = gpio_t_i[b];
        end
      end
      po_q.push_back(e_o);
      pt_q.push_back(e_t);
      pi_q.push_back(exp_pad_i);
    end
  endtask

  task automatic run_pdm();
    rp_pkg::pdm_lvl_t lvl [`RP_PDM_CHN];
    int ones [`RP_PDM_CHN];
    logic [31:0] r;
    // levels and accumulators still at their reset value
    m_we  = 1'b0;
    m_pdm = '0;
    for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
      m_lvl[ch] = '0;
      m_acc[ch] = '0;
    end
    for (int rnd = 0; rnd < PDM_ROUNDS; rnd++) begin
      for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
        r = $urandom;
        lvl[ch] = r[7:0];
      end
      // both ends of the range in the first round
      if (rnd == 0) begin
        lvl[0] = 8'h00;
        lvl[1] = 8'hff;
      end
      for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
        pdm_step_check();
        pdm_we_i    = 1'b1;
        pdm_addr_i  = ch[`RP_PDM_AW-1:0];
        pdm_wdata_i = lvl[ch];
      end
      pdm_step_check();
      pdm_we_i = 1'b0;
      pdm_step_check();
      for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
        ones[ch] = 0;
      end
      for (int k = 0; k < PDM_WIN; k++) begin
        pdm_step_check();
        for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
          ones[ch] += int'(pdm_o[ch]);
        end
      end
      for (int ch = 0; ch < `RP_PDM_CHN; ch++) begin
        check("pdm_o ones count", 32'(ones[ch]), 32'(lvl[ch]));
      end
    end
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    top_rst     = 1'b1;
    adc_raw_i   = '0;
    dac_smp_i   = '0;
    dac_vld_i   = '0;
    exp_mode_i  = '0;
    gpio_o_i    = '0;
    gpio_t_i    = '0;
    lg_i        = '0;
    exp_pad_i   = '0;
    pdm_we_i    = 1'b0;
    pdm_addr_i  = '0;
    pdm_wdata_i = '0;

    repeat (RST_CYCLES) begin
      tick();
      check_idle_pads();
      check("dac_code_o", 32'(dac_code_o), 32'd0);
      check("dac_rst_o", 32'(dac_rst_o), 32'd1);
    end
    top_rst = 1'b0;
    // staged reset releases first, DAC reset one edge later
    tick();
    check_idle_pads();
    check("dac_code_o", 32'(dac_code_o), 32'd0);
    check("dac_rst_o", 32'(dac_rst_o), 32'd1);
    tick();
    check_idle_pads();
    check("dac_rst_o", 32'(dac_rst_o), 32'd0);
    end_test("reset");

    run_adc();
    end_test("adc_conv");
    run_dac();
    end_test("dac_capture");
    run_gpio();
    end_test("gpio_mux");
    run_pdm();
    end_test("pdm_density");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             n_tests, n_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hw
hw/rp_pkg.sv
hw/adc_frontend.sv
hw/dac_backend.sv
hw/exp_gpio_mux.sv
hw/pdm_bank.sv
hw/rp_io_top.sv
tb/tb_rp_io_top.sv

/* Makefile */
# Verilator build and run of the I/O datapath testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_io_top
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
